/* sim.f */
verilog/imul_pkg.sv
verilog/imul_unit.sv
verilog/imul_dispatch.sv
verilog/imul_collect.sv
verilog/imul_bank.sv
test/imul_sva.sv
test/imul_tb.sv

/* test/imul_tb.sv */
// --------------------
// Testbench for the multiplier bank
// Directed host traffic checked against a reference queue
// --------------------

`timescale 1ns/1ps

module imul_tb
  import imul_pkg::*;
();

  // Cycles any single wait may take
  localparam int WAIT_LIMIT = 2000;

  logic                  clk;
  logic                  reset;
  logic                  in_req;
  logic [DATA_WIDTH-1:0] in_a;
  logic [DATA_WIDTH-1:0] in_b;
  logic                  out_ack;
  logic                  in_ack;
  logic                  out_req;
  logic [DATA_WIDTH-1:0] out_result;

  integer seed;

  // Pending operands and expected products, in issue order
  logic [DATA_WIDTH-1:0] a_q[$];
  logic [DATA_WIDTH-1:0] b_q[$];
  logic [DATA_WIDTH-1:0] ref_q[$];

  // Accepted and returned counts, longest wait for in_ack
  int sent_cnt;
  int recv_cnt;
  int max_stall;

  imul_bank UUT (
    .clk        (clk),
    .reset      (reset),
    .in_req     (in_req),
    .in_a       (in_a),
    .in_b       (in_b),
    .out_ack    (out_ack),
    .in_ack     (in_ack),
    .out_req    (out_req),
    .out_result (out_result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------
  // Checks and failures
  // --------------------

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic report_failure(input string what);
    $display("Failure: %s", what);
    $display("*** FAILED ***");
    $fatal(1, "test stopped");
  endtask

  // A handshake assertion failure ends the run at once
  always @(negedge clk) begin
    if (UUT.u_sva.assert_fails != 0) begin
      report_failure("host handshake assertion failed");
    end
  end

  // --------------------
  // Host side of both channels
  // --------------------

  task automatic send_op(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
    int n;
    // Low word of the product is all the bank returns
    ref_q.push_back(a * b);
    @(posedge clk);
    in_req <= 1'b1;
    in_a   <= a;
    in_b   <= b;
    n = 0;
    @(negedge clk);
    while (!in_ack) begin
      n++;
      if (n > WAIT_LIMIT) report_failure("in_ack never rose after in_req");
      @(negedge clk);
    end
    if (n > max_stall) max_stall = n;
    sent_cnt++;
    // Never more in flight than there are units
    if (sent_cnt - recv_cnt > NUM_UNITS) begin
      report_failure("more operations accepted than the bank can hold");
    end
    @(posedge clk);
    in_req <= 1'b0;
    n = 0;
    @(negedge clk);
    while (in_ack) begin
      n++;
      if (n > WAIT_LIMIT) report_failure("in_ack stayed high after in_req dropped");
      @(negedge clk);
    end
  endtask

  task automatic recv_result(input int ack_delay);
    int                    n;
    logic [DATA_WIDTH-1:0] exp;
    n = 0;
    @(negedge clk);
    while (!out_req) begin
      n++;
      if (n > WAIT_LIMIT) report_failure("out_req never rose for a pending result");
      @(negedge clk);
    end
    recv_cnt++;
    if (ref_q.size() == 0) begin
      report_failure("result arrived with no operation outstanding");
    end else begin
      exp = ref_q.pop_front();
      check_value("out_result", out_result, exp);
    end
    // Slow host, out_req must hold meanwhile
    repeat (ack_delay) @(posedge clk);
    @(posedge clk);
    out_ack <= 1'b1;
    n = 0;
    @(negedge clk);
    while (out_req) begin
      n++;
      if (n > WAIT_LIMIT) report_failure("out_req stayed high after out_ack");
      @(negedge clk);
    end
    @(posedge clk);
    out_ack <= 1'b0;
  endtask

  // Sends all queued operands while draining results in parallel
  task automatic run_queued(input int ack_delay);
    int count;
    count     = a_q.size();
    sent_cnt  = 0;
    recv_cnt  = 0;
    max_stall = 0;
    fork
      begin
        for (int i = 0; i < count; i++) send_op(a_q[i], b_q[i]);
      end
      begin
        for (int i = 0; i < count; i++) recv_result(ack_delay);
      end
    join
    a_q.delete();
    b_q.delete();
    // No duplicate result may follow
    repeat (40) begin
      @(negedge clk);
      check_value("out_req", out_req, 1'b0);
    end
  endtask

  // --------------------
  // Directed tests
  // --------------------

  task automatic test_reset_state();
    repeat (5) begin
      @(negedge clk);
      check_value("in_ack", in_ack, 1'b0);
      check_value("out_req", out_req, 1'b0);
    end
  endtask

  task automatic run_single(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
    a_q.push_back(a);
    b_q.push_back(b);
    run_queued(0);
  endtask

  task automatic test_single_products();
    run_single(32'd3, 32'd5);
    // Zero A with a busy B, then early exit on B of zero
    run_single(32'h0, 32'h12345678);
    run_single(32'h12345678, 32'h0);
    // Full 32 steps
    run_single(32'hffffffff, 32'hffffffff);
    run_single(32'h80000000, 32'h2);
    // Long zero run skipped in one step
    run_single(32'h7, 32'h80000000);
  endtask

  task automatic test_streaming();
    repeat (24) begin
      a_q.push_back($random(seed));
      b_q.push_back($random(seed));
    end
    run_queued(0);
  endtask

  task automatic test_back_pressure();
    repeat (8) begin
      a_q.push_back($random(seed));
      b_q.push_back($random(seed));
    end
    run_queued(40);
    // With every unit holding a result, the sender must wait
    if (max_stall <= 20) report_failure("in_ack never stalled with all units full");
  endtask

  task automatic test_mixed_latencies();
    a_q = '{32'h3, 32'h5, 32'h7, 32'h9, 32'hb, 32'hd, 32'hffff, 32'h2};
    // Long B first, then operands that finish almost at once
    b_q = '{32'hffffffff, 32'h0, 32'h100, 32'hffffffff,
            32'h80000000, 32'h1, 32'hffffffff, 32'h0};
    run_queued(0);
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    seed    = 8;
    reset   = 1'b1;
    in_req  = 1'b0;
    in_a    = '0;
    in_b    = '0;
    out_ack = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_single_products();
    test_streaming();
    test_back_pressure();
    test_mixed_latencies();
    if (UUT.u_sva.assert_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* test/imul_sva.sv */
// --------------------
// Four-phase rules on both host channels
// --------------------

`timescale 1ns/1ps

module imul_sva
  import imul_pkg::*;
(
  input logic                  clk,
  input logic                  reset,
  input logic                  in_req,
  input logic                  in_ack,
  input logic                  out_req,
  input logic                  out_ack,
  input logic [DATA_WIDTH-1:0] out_result
);

  // Failed assertions so far
  int assert_fails = 0;

  // Ack only answers a request that was seen
  a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(in_ack) |-> $past(in_req))
    else begin
      assert_fails++;
      $error("in_ack rose without in_req");
    end

  // Result held for the whole request phase
  a_result_stable: assert property (@(posedge clk) disable iff (reset)
    (out_req && $past(out_req)) |-> $stable(out_result))
    else begin
      assert_fails++;
      $error("out_result changed while out_req was high");
    end

  a_req_waits_ack: assert property (@(posedge clk) disable iff (reset)
    $fell(out_req) |-> $past(out_ack))
    else begin
      assert_fails++;
      $error("out_req fell before out_ack");
    end

  a_ack_waits_drop: assert property (@(posedge clk) disable iff (reset)
    $fell(in_ack) |-> !$past(in_req))
    else begin
      assert_fails++;
      $error("in_ack fell while in_req was high");
    end

endmodule

bind imul_bank imul_sva u_sva (.*);

/* verilog/imul_bank.sv */
// --------------------
// Multiplier bank top level
// Dispatcher, NUM_UNITS units and an in-order collector
// --------------------

`timescale 1ns/1ps

module imul_bank
  import imul_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_req,
  input  logic [DATA_WIDTH-1:0] in_a,
  input  logic [DATA_WIDTH-1:0] in_b,
  input  logic                  out_ack,
  output logic                  in_ack,
  output logic                  out_req,
  output logic [DATA_WIDTH-1:0] out_result
);

  // --------------------
  // Internal start/done paths
  // --------------------

  logic [NUM_UNITS-1:0]                 unit_start;
  logic [NUM_UNITS-1:0]                 unit_busy;
  logic [NUM_UNITS-1:0]                 unit_done;
  logic [NUM_UNITS-1:0]                 unit_take;
  logic [NUM_UNITS-1:0][DATA_WIDTH-1:0] unit_result;

  // Operand bus shared by all units
  logic [DATA_WIDTH-1:0]                op_a;
  logic [DATA_WIDTH-1:0]                op_b;

  // Host request side
  imul_dispatch u_dispatch (
    .clk        (clk),
    .reset      (reset),
    .in_req     (in_req),
    .in_a       (in_a),
    .in_b       (in_b),
    .unit_busy  (unit_busy),
    .in_ack     (in_ack),
    .unit_start (unit_start),
    .op_a       (op_a),
    .op_b       (op_b)
  );

  // One multiplier per slot
  for (genvar i = 0; i < NUM_UNITS; i++) begin : g_unit
    imul_unit u_unit (
      .clk    (clk),
      .reset  (reset),
      .start  (unit_start[i]),
      .op_a   (op_a),
      .op_b   (op_b),
      .take   (unit_take[i]),
      .busy   (unit_busy[i]),
      .done   (unit_done[i]),
      .result (unit_result[i])
    );
  end

  // Host response side, same order as issue
  imul_collect u_collect (
    .clk         (clk),
    .reset       (reset),
    .unit_done   (unit_done),
    .unit_result (unit_result),
    .out_ack     (out_ack),
    .unit_take   (unit_take),
    .out_req     (out_req),
    .out_result  (out_result)
  );

endmodule

/* verilog/imul_collect.sv */
// --------------------
// Response side: drains units round-robin
// and returns results by four-phase handshake
// --------------------

`timescale 1ns/1ps

module imul_collect
  import imul_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [NUM_UNITS-1:0]                 unit_done,
  input  logic [NUM_UNITS-1:0][DATA_WIDTH-1:0] unit_result,
  input  logic                                 out_ack,
  output logic [NUM_UNITS-1:0]                 unit_take,
  output logic                                 out_req,
  output logic [DATA_WIDTH-1:0]                out_result
);

  hs_state_t                 state;
  logic [UNIT_IDX_WIDTH-1:0] ptr;
  logic                      send;

  // --------------------
  // Take logic
  // --------------------

  // Pointed unit has a result and the host channel is idle
  assign send = (state == HS_WAIT_REQ) && unit_done[ptr];

  // Take fires in the same cycle the result is copied
  always_comb begin
    unit_take      = '0;
    unit_take[ptr] = send;
  end

  // --------------------
  // Handshake FSM and pointer
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= HS_WAIT_REQ;
      ptr     <= '0;
      out_req <= 1'b0;
    end else begin
      case (state)
        HS_WAIT_REQ: begin
          if (send) begin
            out_req <= 1'b1;
            state   <= HS_BUSY;
            // Next result must come from the next unit in order
            if (ptr == UNIT_IDX_WIDTH'(NUM_UNITS - 1)) begin
              ptr <= '0;
            end else begin
              ptr <= ptr + 1'b1;
            end
          end
        end
        HS_BUSY: begin
          // Req held with stable data until the host acks
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= HS_WAIT_DROP;
          end
        end
        HS_WAIT_DROP: begin
          // Host must release ack before the next req
          if (!out_ack) begin
            state <= HS_WAIT_REQ;
          end
        end
        default: state <= HS_WAIT_REQ;
      endcase
    end
  end

  // --------------------
  // Result register
  // --------------------

  // Only loads on send, so it holds through the whole handshake
  always_ff @(posedge clk) begin
    if (send) begin
      out_result <= unit_result[ptr];
    end
  end

endmodule

/* verilog/imul_dispatch.sv */
// --------------------
// Request side: four-phase receiver
// Issues operands to units in round-robin order
// --------------------

`timescale 1ns/1ps

module imul_dispatch
  import imul_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_req,
  input  logic [DATA_WIDTH-1:0] in_a,
  input  logic [DATA_WIDTH-1:0] in_b,
  input  logic [NUM_UNITS-1:0]  unit_busy,
  output logic                  in_ack,
  output logic [NUM_UNITS-1:0]  unit_start,
  output logic [DATA_WIDTH-1:0] op_a,
  output logic [DATA_WIDTH-1:0] op_b
);

  hs_state_t                 state;
  logic [UNIT_IDX_WIDTH-1:0] ptr;
  logic                      issue;

  // Request pending and the unit under the pointer is free
  assign issue = in_req && !unit_busy[ptr] &&
                 ((state == HS_WAIT_REQ) || (state == HS_BUSY));

  // --------------------
  // Handshake FSM and pointer
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= HS_WAIT_REQ;
      ptr        <= '0;
      in_ack     <= 1'b0;
      unit_start <= '0;
    end else begin
      // Start is a single-cycle pulse
      unit_start <= '0;
      case (state)
        HS_WAIT_REQ, HS_BUSY: begin
          if (issue) begin
            unit_start[ptr] <= 1'b1;
            in_ack          <= 1'b1;
            state           <= HS_WAIT_DROP;
            if (ptr == UNIT_IDX_WIDTH'(NUM_UNITS - 1)) begin
              ptr <= '0;
            end else begin
              ptr <= ptr + 1'b1;
            end
          end else if (in_req) begin
            // Stalled on a busy unit
            state <= HS_BUSY;
          end else begin
            state <= HS_WAIT_REQ;
          end
        end
        HS_WAIT_DROP: begin
          // Release ack only after the host lets go of req
          if (!in_req) begin
            in_ack <= 1'b0;
            state  <= HS_WAIT_REQ;
          end
        end
        default: state <= HS_WAIT_REQ;
      endcase
    end
  end

  // Shared operand bus, valid from the start pulse onward
  always_ff @(posedge clk) begin
    if (issue) begin
      op_a <= in_a;
      op_b <= in_b;
    end
  end

endmodule

/* verilog/imul_unit.sv */
// --------------------
// Iterative shift-add multiplier unit
// Skips runs of zero bits in B, exits early when B is empty
// --------------------

`timescale 1ns/1ps

module imul_unit
  import imul_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic [DATA_WIDTH-1:0] op_a,
  input  logic [DATA_WIDTH-1:0] op_b,
  input  logic                  take,
  output logic                  busy,
  output logic                  done,
  output logic [DATA_WIDTH-1:0] result
);

  // --------------------
  // State and registers
  // --------------------

  unit_state_t state;
  unit_state_t state_next;

  // A shifts left, B shifts right, acc collects partial sums
  logic [DATA_WIDTH-1:0]  a_reg;
  logic [DATA_WIDTH-1:0]  b_reg;
  logic [DATA_WIDTH-1:0]  acc;

  // Bits of B consumed so far
  logic [SHAMT_WIDTH-1:0] cnt;

  // Next values for one step
  logic [DATA_WIDTH-1:0]  a_next;
  logic [DATA_WIDTH-1:0]  b_next;
  logic [DATA_WIDTH-1:0]  acc_next;
  logic [SHAMT_WIDTH-1:0] cnt_next;
  logic [SHAMT_WIDTH-1:0] shamt;
  logic [SHAMT_WIDTH-1:0] bits_left;
  logic [SHAMT_WIDTH-1:0] tz;
  logic                   calc_end;
  logic                   load;

  // Trailing zero count, DATA_WIDTH when the value is zero
  function automatic logic [SHAMT_WIDTH-1:0] trailing_zeros(
    input logic [DATA_WIDTH-1:0] v
  );
    logic [SHAMT_WIDTH-1:0] n;
    n = SHAMT_WIDTH'(DATA_WIDTH);
    // Scan downwards so the lowest set bit wins
    for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
      if (v[i]) begin
        n = SHAMT_WIDTH'(i);
      end
    end
    return n;
  endfunction

  // --------------------
  // Step datapath
  // --------------------

  assign load      = (state == UNIT_IDLE) && start;
  assign bits_left = SHAMT_WIDTH'(DATA_WIDTH) - cnt;
  assign tz        = trailing_zeros(b_reg);

  always_comb begin
    // Set low bit: add A, then move on by one bit
    if (b_reg[0]) begin
      shamt    = SHAMT_WIDTH'(1);
      acc_next = acc + a_reg;
    end else begin
      // Zero run: jump over it, never past the end of B
      shamt    = (tz > bits_left) ? bits_left : tz;
      acc_next = acc;
    end
    a_next   = a_reg << shamt;
    b_next   = b_reg >> shamt;
    cnt_next = cnt + shamt;
  end

  // Finished once B has no set bits left or all bits are consumed
  assign calc_end = (b_next == '0) || (cnt_next == SHAMT_WIDTH'(DATA_WIDTH));

  // --------------------
  // Control FSM
  // --------------------

  always_comb begin
    state_next = state;
    case (state)
      UNIT_IDLE: begin
        if (start) begin
          state_next = UNIT_CALC;
        end
      end
      UNIT_CALC: begin
        if (calc_end) begin
          state_next = UNIT_DONE;
        end
      end
      UNIT_DONE: begin
        // Hold the result until the collector takes it
        if (take) begin
          state_next = UNIT_IDLE;
        end
      end
      default: state_next = UNIT_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= UNIT_IDLE;
      cnt   <= '0;
    end else begin
      state <= state_next;
      if (load) begin
        cnt <= '0;
      end else if (state == UNIT_CALC) begin
        cnt <= cnt_next;
      end
    end
  end

  // Operand and accumulator registers
  always_ff @(posedge clk) begin
    if (load) begin
      a_reg <= op_a;
      b_reg <= op_b;
      acc   <= '0;
    end else if (state == UNIT_CALC) begin
      a_reg <= a_next;
      b_reg <= b_next;
      acc   <= acc_next;
    end
  end

  // --------------------
  // Outputs
  // --------------------

  // Busy covers both the calculation and the wait for take
  assign busy   = (state != UNIT_IDLE);
  assign done   = (state == UNIT_DONE);
  assign result = acc;

endmodule

/* verilog/imul_pkg.sv */
// --------------------
// Shared constants and FSM state types
// for the iterative multiplier bank
// --------------------

package imul_pkg;

  // --------------------
  // Datapath sizing
  // --------------------

  // Operand and result width
  localparam int DATA_WIDTH = 32;

  // Shift amount and bit counter, must hold DATA_WIDTH itself
  localparam int SHAMT_WIDTH = 6;

  // --------------------
  // Bank sizing
  // --------------------

  // Number of multiplier units in the bank
  localparam int NUM_UNITS = 4;

  // Round-robin pointer width
  localparam int UNIT_IDX_WIDTH = 2;

  // --------------------
  // FSM states
  // --------------------

  // Multiplier unit control
  typedef enum logic [1:0] {
    UNIT_IDLE,
    UNIT_CALC,
    UNIT_DONE
  } unit_state_t;

  // Four-phase host handshake, shared by both host channels
  typedef enum logic [1:0] {
    HS_WAIT_REQ,
    HS_BUSY,
    HS_WAIT_DROP
  } hs_state_t;

endpackage
